//--- common/noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// batch geometry held by the ifmap buffer
`define NOC_LINES       35
`define NOC_LINE_BYTES  256

// pe array seen by the diagonal buses
`define NOC_PE_ROWS     6
`define NOC_PE_COLS     7
`define NOC_LANES       12

// bytes carried by one packet
`define NOC_PKT_BYTES   4

// pointer and complete_count widths
`define NOC_IDX_W       6
`define NOC_CNT_W       5

// layer 2 sweep, one end line per iteration
`define L2_LINE_END_0   10
`define L2_LINE_END_1   17
`define L2_LINE_END_2   24
`define L2_LINE_END_3   30
`define L2_LINE_STEP    7
`define L2_LAST_ELEM    7

// complete_count seen with the conv_complete that frees a layer 2 batch
`define L2_FREE_COUNT   3

// layer 3 sweep, single iteration
`define L3_LINE_END     14
`define L3_LAST_ELEM    3

`endif

//--- common/noc_pkg.sv
`include "noc_consts.svh"

package noc_pkg;

    // active layer, sampled on start
    // null means no batch configured yet
    typedef enum logic [1:0] {
        NULL,
        LAYER2,
        LAYER3
    } layer_e;

    // line pointer, element group pointer or packet index
    typedef logic [`NOC_IDX_W-1:0] ptr_t;

    // number of convolutions the pe array has completed
    typedef logic [`NOC_CNT_W-1:0] count_t;

endpackage

//--- common/packet_pkg.sv
`include "noc_consts.svh"

package packet_pkg;

    typedef logic [7:0] byte_t;

    // one packet as seen on a diagonal bus
    // byte 0 sits in data[0]
    typedef struct packed {
        logic                           valid;
        byte_t [`NOC_PKT_BYTES-1:0]     data;
        noc_pkg::ptr_t                  packet_idx;
    } pe_in_packet_t;

    // one bit per diagonal bus
    typedef logic [`NOC_LANES-1:0] lane_mask_t;

endpackage

//--- ifmap/ifmap_buffer.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module ifmap_buffer (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                start,
    input  logic                                                start_conv,
    input  logic                                                conv_complete,
    input  noc_pkg::layer_e                                     layer_type_in,
    input  noc_pkg::count_t                                     complete_count,
    input  packet_pkg::byte_t [`NOC_LINES-1:0][`NOC_LINE_BYTES-1:0] ifmap_data_in,
    input  noc_pkg::ptr_t                                       rd_line,
    input  noc_pkg::ptr_t                                       rd_elem,
    output noc_pkg::layer_e                                     layer,
    output logic                                                data_valid,
    output logic                                                load,
    output packet_pkg::byte_t [`NOC_PKT_BYTES-1:0]              rd_word,
    output logic                                                free_ifmap_buffer
);

    import noc_pkg::*;
    import packet_pkg::*;

    byte_t [`NOC_LINES-1:0][`NOC_LINE_BYTES-1:0] pad_q;
    logic free_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer <= NULL;
        end else if (start) begin
            layer <= layer_type_in;
        end
    end

    // input data is only stable one cycle after start_conv
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load <= 1'b0;
        end else begin
            load <= start_conv;
        end
    end

    // layer 2 frees after its last iteration, layer 3 on every completion
    assign free_hit = conv_complete &&
                      ((layer == LAYER2 && complete_count == count_t'(`L2_FREE_COUNT)) ||
                       layer == LAYER3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else if (start) begin
            data_valid <= 1'b0;
        end else if (load) begin
            data_valid <= 1'b1;
        end else if (free_hit) begin
            data_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_ifmap_buffer <= 1'b0;
        end else begin
            free_ifmap_buffer <= free_hit;
        end
    end

    // padded batch
    // layer 2 pads two lines on top and two bytes on the left
    // layer 3 pads one line and one byte
    always_ff @(posedge clk) begin
        if (start) begin
            pad_q <= '0;
        end else if (load) begin
            case (layer)
                LAYER2: begin
                    for (int i = 0; i < 2; i++) begin
                        pad_q[i] <= '0;
                    end
                    for (int i = 2; i < `NOC_LINES; i++) begin
                        pad_q[i] <= {ifmap_data_in[i-2][`NOC_LINE_BYTES-3:0], 16'h0000};
                    end
                end
                LAYER3: begin
                    pad_q[0] <= '0;
                    for (int i = 1; i < `NOC_LINES; i++) begin
                        pad_q[i] <= {ifmap_data_in[i-1][`NOC_LINE_BYTES-2:0], 8'h00};
                    end
                end
                default: begin
                    pad_q <= '0;
                end
            endcase
        end else if (free_hit) begin
            pad_q <= '0;
        end
    end

    // one element group of the addressed line
    always_comb begin
        for (int j = 0; j < `NOC_PKT_BYTES; j++) begin
            rd_word[j] = pad_q[rd_line][rd_elem * `NOC_PKT_BYTES + j];
        end
    end

endmodule

//--- ifmap/read_sequencer.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module read_sequencer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic                                    start_conv,
    input  logic                                    load,
    input  noc_pkg::layer_e                         layer,
    input  logic                                    data_valid,
    input  noc_pkg::count_t                         complete_count,
    input  packet_pkg::byte_t [`NOC_PKT_BYTES-1:0]  rd_word,
    input  logic                                    line_blocked,
    output noc_pkg::ptr_t                           rd_line,
    output noc_pkg::ptr_t                           rd_elem,
    output noc_pkg::ptr_t                           packet_idx,
    output packet_pkg::pe_in_packet_t               packet
);

    import noc_pkg::*;
    import packet_pkg::*;

    logic enable;
    ptr_t line_ptr;
    ptr_t elem_ptr;
    ptr_t line_start;
    ptr_t line_end;
    ptr_t last_elem;
    logic advance;
    logic line_wrap;
    logic sweep_done;

    // sweep bounds for the current layer and iteration
    always_comb begin
        line_start = '0;
        line_end   = '0;
        last_elem  = '0;
        case (layer)
            LAYER2: begin
                last_elem = ptr_t'(`L2_LAST_ELEM);
                case (complete_count)
                    count_t'(1): begin
                        line_start = ptr_t'(`L2_LINE_STEP);
                        line_end   = ptr_t'(`L2_LINE_END_1);
                    end
                    count_t'(2): begin
                        line_start = ptr_t'(2 * `L2_LINE_STEP);
                        line_end   = ptr_t'(`L2_LINE_END_2);
                    end
                    count_t'(3): begin
                        line_start = ptr_t'(3 * `L2_LINE_STEP);
                        line_end   = ptr_t'(`L2_LINE_END_3);
                    end
                    default: begin
                        line_start = '0;
                        line_end   = ptr_t'(`L2_LINE_END_0);
                    end
                endcase
            end
            LAYER3: begin
                line_end  = ptr_t'(`L3_LINE_END);
                last_elem = ptr_t'(`L3_LAST_ELEM);
            end
            default: begin
                line_end = '0;
            end
        endcase
    end

    // load cycle belongs to the buffer, no step there
    assign advance    = enable && !load && !line_blocked;
    assign line_wrap  = (line_ptr == line_end);
    assign sweep_done = advance && line_wrap && (elem_ptr == last_elem);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else if (start) begin
            enable <= 1'b0;
        end else if (sweep_done) begin
            enable <= 1'b0;
        end else if (start_conv) begin
            enable <= 1'b1;
        end
    end

    // line pointer is the inner loop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (start) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (load) begin
            line_ptr <= line_start;
            elem_ptr <= '0;
        end else if (advance) begin
            if (line_wrap) begin
                line_ptr <= line_start;
                elem_ptr <= elem_ptr + 1'b1;
            end else begin
                line_ptr <= line_ptr + 1'b1;
            end
        end
    end

    assign rd_line    = line_ptr;
    assign rd_elem    = elem_ptr;
    assign packet_idx = line_ptr - line_start;

    always_comb begin
        packet.valid      = advance && data_valid;
        packet.data       = rd_word;
        packet.packet_idx = packet_idx;
        // last group carries only three real bytes
        if (elem_ptr == last_elem) begin
            packet.data[`NOC_PKT_BYTES-1] = '0;
        end
    end

endmodule

//--- diagbus/diagonal_router.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module diagonal_router (
    input  noc_pkg::layer_e                                 layer,
    input  noc_pkg::count_t                                 complete_count,
    input  noc_pkg::ptr_t                                   packet_idx,
    input  packet_pkg::pe_in_packet_t                       packet,
    input  logic [`NOC_PE_ROWS-1:0][`NOC_PE_COLS-1:0]       pe_full,
    output logic                                            line_blocked,
    output packet_pkg::pe_in_packet_t [`NOC_LANES-1:0]      diag_bus
);

    import noc_pkg::*;
    import packet_pkg::*;

    // layer 3 lower rows reach line r+c+4, at most 15
    localparam int LINE_SLOTS = 16;

    logic [LINE_SLOTS-1:0] l2_full;
    logic [LINE_SLOTS-1:0] l3_full;
    logic l2_last_iter;
    logic idx_in_range;
    lane_mask_t lane_mask;

    // column 6 holds no work in the last layer 2 iteration
    assign l2_last_iter = (complete_count == count_t'(`L2_FREE_COUNT));

    // fold pe_full onto the line each pe consumes
    always_comb begin
        l2_full = '0;
        l3_full = '0;
        for (int r = 0; r < `NOC_PE_ROWS; r++) begin
            for (int c = 0; c < `NOC_PE_COLS; c++) begin
                // row 5 idle in layer 2
                if (r <= 4 && !(l2_last_iter && c == `NOC_PE_COLS - 1)) begin
                    l2_full[r+c] = l2_full[r+c] | pe_full[r][c];
                end
                if (r < 3) begin
                    l3_full[r+c] = l3_full[r+c] | pe_full[r][c];
                end else begin
                    l3_full[r+c+4] = l3_full[r+c+4] | pe_full[r][c];
                end
            end
        end
    end

    assign idx_in_range = (packet_idx < ptr_t'(LINE_SLOTS));

    always_comb begin
        case (layer)
            LAYER2:  line_blocked = idx_in_range && l2_full[packet_idx[3:0]];
            LAYER3:  line_blocked = idx_in_range && l3_full[packet_idx[3:0]];
            default: line_blocked = 1'b0;
        endcase
    end

    // lane pattern
    // layer 3 lines 7 and 8 feed both pe halves, so two lanes each
    always_comb begin
        lane_mask = '0;
        case (layer)
            LAYER2: begin
                lane_mask = lane_mask_t'(1) << packet_idx;
            end
            LAYER3: begin
                if (packet_idx <= ptr_t'(6)) begin
                    lane_mask = lane_mask_t'(1) << packet_idx;
                end else if (packet_idx <= ptr_t'(8)) begin
                    lane_mask = (lane_mask_t'(1) << packet_idx) |
                                (lane_mask_t'(1) << (packet_idx - ptr_t'(4)));
                end else if (packet_idx <= ptr_t'(`L3_LINE_END)) begin
                    lane_mask = lane_mask_t'(1) << (packet_idx - ptr_t'(4));
                end
            end
            default: begin
                lane_mask = '0;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < `NOC_LANES; i++) begin
            if (packet.valid && lane_mask[i]) begin
                diag_bus[i] = packet;
            end else begin
                diag_bus[i] = '0;
            end
        end
    end

endmodule

//--- hw/noc_top.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                start,
    input  logic                                                start_conv,
    input  logic                                                conv_complete,
    input  noc_pkg::layer_e                                     layer_type_in,
    input  noc_pkg::count_t                                     complete_count,
    input  packet_pkg::byte_t [`NOC_LINES-1:0][`NOC_LINE_BYTES-1:0] ifmap_data_in,
    input  logic [`NOC_PE_ROWS-1:0][`NOC_PE_COLS-1:0]           pe_full,
    output logic                                                free_ifmap_buffer,
    output packet_pkg::pe_in_packet_t [`NOC_LANES-1:0]          diag_bus
);

    import noc_pkg::*;
    import packet_pkg::*;

    layer_e layer;
    logic data_valid;
    logic load;
    byte_t [`NOC_PKT_BYTES-1:0] rd_word;
    ptr_t rd_line;
    ptr_t rd_elem;
    ptr_t packet_idx;
    pe_in_packet_t packet;
    logic line_blocked;

    ifmap_buffer i_ifmap_buffer (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_conv        (start_conv),
        .conv_complete     (conv_complete),
        .layer_type_in     (layer_type_in),
        .complete_count    (complete_count),
        .ifmap_data_in     (ifmap_data_in),
        .rd_line           (rd_line),
        .rd_elem           (rd_elem),
        .layer             (layer),
        .data_valid        (data_valid),
        .load              (load),
        .rd_word           (rd_word),
        .free_ifmap_buffer (free_ifmap_buffer)
    );

    read_sequencer i_read_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .start_conv     (start_conv),
        .load           (load),
        .layer          (layer),
        .data_valid     (data_valid),
        .complete_count (complete_count),
        .rd_word        (rd_word),
        .line_blocked   (line_blocked),
        .rd_line        (rd_line),
        .rd_elem        (rd_elem),
        .packet_idx     (packet_idx),
        .packet         (packet)
    );

    diagonal_router i_diagonal_router (
        .layer          (layer),
        .complete_count (complete_count),
        .packet_idx     (packet_idx),
        .packet         (packet),
        .pe_full        (pe_full),
        .line_blocked   (line_blocked),
        .diag_bus       (diag_bus)
    );

endmodule

//--- testbench/tb_noc_model.svh
`ifndef TB_NOC_MODEL_SVH
`define TB_NOC_MODEL_SVH

// padding is two lines and two bytes for layer 2, one of each for layer 3
function automatic logic [7:0] padded_byte(layer_e ly, int line, int b);
    int pad;
    pad = (ly == LAYER2) ? 2 : 1;
    if (line < pad || b < pad || b - pad >= `NOC_LINE_BYTES || line - pad >= `NOC_LINES) begin
        return 8'h00;
    end
    return img[line-pad][b-pad];
endfunction

function automatic int sweep_first(layer_e ly, int k);
    return (ly == LAYER2) ? `L2_LINE_STEP * k : 0;
endfunction

function automatic int sweep_last(layer_e ly, int k);
    if (ly == LAYER3) return `L3_LINE_END;
    if (ly != LAYER2) return 0;
    case (k)
        1: return `L2_LINE_END_1;
        2: return `L2_LINE_END_2;
        3: return `L2_LINE_END_3;
        default: return `L2_LINE_END_0;
    endcase
endfunction

function automatic int last_group(layer_e ly);
    if (ly == LAYER2) return `L2_LAST_ELEM;
    if (ly == LAYER3) return `L3_LAST_ELEM;
    return 0;
endfunction

function automatic int sweep_lines(layer_e ly, int k);
    return sweep_last(ly, k) - sweep_first(ly, k) + 1;
endfunction

function automatic int sweep_total(layer_e ly, int k);
    return sweep_lines(ly, k) * (last_group(ly) + 1);
endfunction

// line pointer runs inner, so the index wraps every sweep_lines packets
function automatic int expected_idx(layer_e ly, int k, int seq);
    return seq % sweep_lines(ly, k);
endfunction

function automatic logic [31:0] expected_word(layer_e ly, int k, int seq);
    int line;
    int grp;
    logic [31:0] w;
    line = sweep_first(ly, k) + expected_idx(ly, k, seq);
    grp = seq / sweep_lines(ly, k);
    for (int j = 0; j < `NOC_PKT_BYTES; j++) begin
        w[8*j +: 8] = padded_byte(ly, line, `NOC_PKT_BYTES * grp + j);
    end
    // last group only has three real bytes
    if (grp == last_group(ly)) w[31:24] = 8'h00;
    return w;
endfunction

// lanes fed by a packet index
function automatic bit on_lane(layer_e ly, int idx, int lane);
    if (ly == LAYER2) return idx == lane;
    if (ly != LAYER3) return 1'b0;
    if (idx <= 6) return idx == lane;
    if (idx <= 8) return idx == lane || idx - 4 == lane;
    if (idx <= `L3_LINE_END) return idx - 4 == lane;
    return 1'b0;
endfunction

function automatic bit blocked_line(layer_e ly, int k, int idx, pe_map_t full);
    bit hit;
    hit = 1'b0;
    for (int r = 0; r < `NOC_PE_ROWS; r++) begin
        for (int c = 0; c < `NOC_PE_COLS; c++) begin
            if (full[r][c]) begin
                if (ly == LAYER2 && r <= 4 && r + c == idx && !(k == 3 && c == 6)) hit = 1'b1;
                if (ly == LAYER3 && r <= 2 && r + c == idx) hit = 1'b1;
                if (ly == LAYER3 && r >= 3 && r + c + 4 == idx) hit = 1'b1;
            end
        end
    end
    return hit;
endfunction

`endif

//--- testbench/tb_noc_top.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module tb_noc_top;

    import noc_pkg::*;
    import packet_pkg::*;

    typedef logic [`NOC_PE_ROWS-1:0][`NOC_PE_COLS-1:0] pe_map_t;

    logic clk;
    logic rst_n;
    logic start;
    logic start_conv;
    logic conv_complete;
    layer_e layer_type_in;
    count_t complete_count;
    byte_t [`NOC_LINES-1:0][`NOC_LINE_BYTES-1:0] ifmap_data_in;
    pe_map_t pe_full;
    logic free_ifmap_buffer;
    pe_in_packet_t [`NOC_LANES-1:0] diag_bus;

    logic [7:0] img [`NOC_LINES][`NOC_LINE_BYTES];
    logic [31:0] lfsr;
    layer_e cur_layer;
    int cur_count;
    int seq_n = 0;
    int sweep_tag = 0;
    int seen_tag = 0;
    int seen [`NOC_LINES][8];
    int valid_cycles = 0;
    int free_cnt = 0;
    int err_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic any_valid;

    `include "tb_noc_model.svh"

    noc_top i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_conv        (start_conv),
        .conv_complete     (conv_complete),
        .layer_type_in     (layer_type_in),
        .complete_count    (complete_count),
        .ifmap_data_in     (ifmap_data_in),
        .pe_full           (pe_full),
        .free_ifmap_buffer (free_ifmap_buffer),
        .diag_bus          (diag_bus)
    );

    always #2 clk = ~clk;

    always_comb begin
        any_valid = 1'b0;
        for (int l = 0; l < `NOC_LANES; l++) begin
            any_valid = any_valid | diag_bus[l].valid;
        end
    end

    task automatic report_mismatch(string sig, logic [63:0] expv, logic [63:0] actv);
        $display("Error at %0d ns: %s expected 0x%0h actual 0x%0h", $time, sig, expv, actv);
        err_cnt++;
    endtask

    task automatic report_problem(string msg);
        $display("Failure at %0d ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit of input data
    task automatic fill_image();
        logic [7:0] v;
        for (int i = 0; i < `NOC_LINES; i++) begin
            for (int b = 0; b < `NOC_LINE_BYTES; b++) begin
                for (int k = 0; k < 8; k++) begin
                    v = {v[6:0], lfsr[0]};
                    lfsr = lfsr_step(lfsr);
                end
                img[i][b] = v;
                ifmap_data_in[i][b] = v;
            end
        end
    endtask

    // packet checks sample on the falling edge, away from the drive time
    for (genvar i = 0; i < `NOC_LANES; i++) begin : g_lane
        a_data: assert property (@(negedge clk) disable iff (!rst_n)
            diag_bus[i].valid |-> diag_bus[i].data == expected_word(cur_layer, cur_count, seq_n))
            else report_mismatch($sformatf("diag_bus[%0d].data", i),
                expected_word(cur_layer, cur_count, seq_n), diag_bus[i].data);
        a_idx: assert property (@(negedge clk) disable iff (!rst_n)
            diag_bus[i].valid |->
                int'(diag_bus[i].packet_idx) == expected_idx(cur_layer, cur_count, seq_n))
            else report_mismatch($sformatf("diag_bus[%0d].packet_idx", i),
                expected_idx(cur_layer, cur_count, seq_n), diag_bus[i].packet_idx);
        a_mask: assert property (@(negedge clk) disable iff (!rst_n)
            any_valid |-> diag_bus[i].valid ==
                on_lane(cur_layer, expected_idx(cur_layer, cur_count, seq_n), i))
            else report_mismatch($sformatf("diag_bus[%0d].valid", i),
                on_lane(cur_layer, expected_idx(cur_layer, cur_count, seq_n), i),
                diag_bus[i].valid);
        a_zero: assert property (@(negedge clk) disable iff (!rst_n)
            !diag_bus[i].valid |-> diag_bus[i] == '0)
            else report_mismatch($sformatf("diag_bus[%0d]", i), 0, diag_bus[i]);
        a_block: assert property (@(negedge clk) disable iff (!rst_n)
            diag_bus[i].valid |->
                !blocked_line(cur_layer, cur_count, int'(diag_bus[i].packet_idx), pe_full))
            else report_problem($sformatf("diag_bus[%0d] is valid while its line is blocked", i));
    end

    // sweep order and packet counts
    always @(negedge clk) begin : observe
        int line;
        line = 0;
        if (sweep_tag != seen_tag) begin
            seen_tag = sweep_tag;
            seq_n <= 0;
            for (int l = 0; l < `NOC_LINES; l++) begin
                for (int g = 0; g < 8; g++) begin
                    seen[l][g] = 0;
                end
            end
        end else if (rst_n && any_valid) begin
            valid_cycles++;
            for (int l = 0; l < `NOC_LANES; l++) begin
                if (diag_bus[l].valid) begin
                    line = sweep_first(cur_layer, cur_count) + int'(diag_bus[l].packet_idx);
                end
            end
            if (seq_n >= sweep_total(cur_layer, cur_count) || line >= `NOC_LINES) begin
                report_problem("valid packet outside the expected sweep");
            end else begin
                seen[line][seq_n / sweep_lines(cur_layer, cur_count)]++;
            end
            seq_n <= seq_n + 1;
        end
        if (free_ifmap_buffer) begin
            free_cnt++;
        end
    end

    // start, then start_conv one cycle later
    task automatic start_sweep(layer_e ly, int k, pe_map_t full);
        layer_type_in = ly;
        complete_count = count_t'(k);
        pe_full = full;
        cur_layer = ly;
        cur_count = k;
        sweep_tag++;
        start = 1'b1;
        step();
        start = 1'b0;
        start_conv = 1'b1;
        step();
        start_conv = 1'b0;
    endtask

    // full sweep with pe_full held for the first hold cycles
    task automatic run_sweep(layer_e ly, int k, pe_map_t full, int hold, int stall_at);
        int total;
        int cycles;
        int v0;
        total = sweep_total(ly, k);
        start_sweep(ly, k, full);
        cycles = 0;
        while (seq_n < total && cycles < total + hold + 20) begin
            step();
            cycles++;
            if (cycles == hold) begin
                if (stall_at >= 0 && seq_n != stall_at) begin
                    report_mismatch("packets before pe_full release", stall_at, seq_n);
                end
                pe_full = '0;
            end
        end
        pe_full = '0;
        if (seq_n < total) begin
            report_problem("sweep timed out before its last packet");
        end else if (stall_at < 0 && cycles != total + 1) begin
            report_mismatch("sweep cycles", total + 1, cycles);
        end
        for (int l = sweep_first(ly, k); l <= sweep_last(ly, k); l++) begin
            for (int g = 0; g <= last_group(ly); g++) begin
                if (seen[l][g] != 1) begin
                    report_mismatch($sformatf("packets of line %0d group %0d", l, g), 1, seen[l][g]);
                end
            end
        end
        v0 = valid_cycles;
        repeat (8) step();
        if (valid_cycles != v0) report_problem("lanes still valid after the sweep ended");
    endtask

    task automatic check_free(int k, int pulses);
        int f0;
        int v0;
        complete_count = count_t'(k);
        f0 = free_cnt;
        conv_complete = 1'b1;
        step();
        conv_complete = 1'b0;
        v0 = valid_cycles;
        if (free_cnt != f0) report_mismatch("free_ifmap_buffer too early", 0, free_cnt - f0);
        step();
        if (free_cnt != f0 + pulses) report_mismatch("free_ifmap_buffer", pulses, free_cnt - f0);
        repeat (4) step();
        if (free_cnt != f0 + pulses) report_mismatch("free pulse count", pulses, free_cnt - f0);
        if (pulses > 0 && valid_cycles != v0) report_problem("lane valid after conv_complete");
    endtask

    task automatic close_test(string name, int e0);
        tests_run++;
        if (err_cnt != e0) begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_cnt - e0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int e0;
        int cycles;
        pe_map_t blk;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        start_conv = 1'b0;
        conv_complete = 1'b0;
        layer_type_in = NULL;
        complete_count = '0;
        pe_full = '0;
        cur_layer = NULL;
        cur_count = 0;
        lfsr = 32'heac9;
        fill_image();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        e0 = err_cnt;
        layer_type_in = LAYER3;
        start = 1'b1;
        step();
        start = 1'b0;
        repeat (10) step();
        if (valid_cycles != 0) report_mismatch("valid lane cycles", 0, valid_cycles);
        if (free_cnt != 0) report_mismatch("free_ifmap_buffer pulses", 0, free_cnt);
        close_test("idle after reset", e0);

        e0 = err_cnt;
        run_sweep(LAYER3, 0, '0, 0, -1);
        close_test("layer 3 sweep", e0);

        e0 = err_cnt;
        run_sweep(LAYER2, 0, '0, 0, -1);
        run_sweep(LAYER2, 3, '0, 0, -1);
        close_test("layer 2 sweeps", e0);

        // pe (4,1) feeds layer 3 line 9
        // pe (0,6) is idle in the last layer 2 pass
        e0 = err_cnt;
        blk = '0;
        blk[4][1] = 1'b1;
        run_sweep(LAYER3, 0, blk, 40, 9);
        blk = '0;
        blk[0][6] = 1'b1;
        run_sweep(LAYER2, 3, blk, 0, -1);
        close_test("back-pressure", e0);

        e0 = err_cnt;
        check_free(1, 0);
        check_free(3, 1);
        // free in the middle of a layer 3 sweep drops every later packet
        start_sweep(LAYER3, 0, '0);
        cycles = 0;
        while (seq_n < 10 && cycles < 40) begin
            step();
            cycles++;
        end
        if (seq_n < 10) report_problem("layer 3 sweep gave no packets before the free");
        check_free(0, 1);
        close_test("buffer free", e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
+incdir+testbench
common/noc_pkg.sv
common/packet_pkg.sv
ifmap/ifmap_buffer.sv
ifmap/read_sequencer.sv
diagbus/diagonal_router.sv
hw/noc_top.sv
testbench/tb_noc_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the noc testbench, result taken from sim.log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_noc_top -f list.f -o sim_noc \
    && ./obj_dir/sim_noc > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -q "Simulation PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
